// File: Makefile
# Verilator flow for the IO platform

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= friscv_io_platform_tb
RTL_TOP   ?= friscv_io_platform
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: logic/friscv_io_decoder.sv
/* IO address decoder */

`timescale 1ns/1ps

module friscv_io_decoder (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  friscv_io_pkg::io_req_t  req,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output friscv_io_pkg::io_cmd_t  cmd
);

    localparam int ADDR_W   = friscv_io_pkg::ADDR_W;
    localparam int OFFSET_W = friscv_io_pkg::OFFSET_W;

    logic [ADDR_W-1:0]          offset_full;
    logic                       in_window;
    logic                       in_gpio;
    logic                       in_clint;
    friscv_io_pkg::io_target_t  target;
    friscv_io_pkg::io_cmd_t     cmd_next;

    // Unsigned wrap also rejects anything below the base
    function automatic logic in_range(
        input logic [ADDR_W-1:0] off,
        input logic [ADDR_W-1:0] base,
        input logic [ADDR_W-1:0] size
    );
        return (off - base) < size;
    endfunction

    //////////////////////////////////////////////////////////////
    // Memory map lookup
    //////////////////////////////////////////////////////////////

    assign offset_full = req.addr - friscv_io_pkg::IO_BASE;
    assign in_window   = offset_full < friscv_io_pkg::IO_SIZE;
    assign in_gpio     = in_window && in_range(offset_full, friscv_io_pkg::GPIO_ADDR,
                                               friscv_io_pkg::GPIO_SIZE);
    assign in_clint    = in_window && in_range(offset_full, friscv_io_pkg::CLINT_ADDR,
                                               friscv_io_pkg::CLINT_SIZE);

    // UART hole and RAM fall through to NONE
    assign target = in_gpio  ? friscv_io_pkg::GPIO  :
                    in_clint ? friscv_io_pkg::CLINT : friscv_io_pkg::NONE;

    always_comb begin
        cmd_next.wr     = req.wr;
        cmd_next.target = target;
        cmd_next.offset = offset_full[OFFSET_W-1:0];
        cmd_next.wdata  = req.wdata;
        cmd_next.strb   = req.strb;
    end

    //////////////////////////////////////////////////////////////
    // Single command slot
    //////////////////////////////////////////////////////////////

    assign req_ready = !cmd_valid || cmd_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            cmd_valid <= 1'b1;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            cmd <= cmd_next;
        end
    end

endmodule

// File: logic/friscv_io_pkg.sv
/* IO platform shared definitions */

package friscv_io_pkg;

    //////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////

    localparam int XLEN     = 32;
    localparam int ADDR_W   = 32;
    localparam int STRB_W   = XLEN / 8;
    localparam int OFFSET_W = 6;

    //////////////////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////////////////

    // IO window, as seen on the data bus
    localparam logic [ADDR_W-1:0] IO_BASE = 32'h0010_0000;
    localparam logic [ADDR_W-1:0] IO_SIZE = 32'd64;

    // Blocks inside the window, UART hole at 0x08 is left unmapped
    localparam logic [ADDR_W-1:0] GPIO_ADDR  = 32'd0;
    localparam logic [ADDR_W-1:0] GPIO_SIZE  = 32'd8;
    localparam logic [ADDR_W-1:0] CLINT_ADDR = 32'd24;
    localparam logic [ADDR_W-1:0] CLINT_SIZE = 32'd20;

    // Register offsets within the window
    localparam logic [OFFSET_W-1:0] REG_GPIO_OUT    = 6'h00;
    localparam logic [OFFSET_W-1:0] REG_GPIO_IN     = 6'h04;
    localparam logic [OFFSET_W-1:0] REG_MSIP        = 6'h18;
    localparam logic [OFFSET_W-1:0] REG_MTIME_LO    = 6'h1C;
    localparam logic [OFFSET_W-1:0] REG_MTIME_HI    = 6'h20;
    localparam logic [OFFSET_W-1:0] REG_MTIMECMP_LO = 6'h24;
    localparam logic [OFFSET_W-1:0] REG_MTIMECMP_HI = 6'h28;

    //////////////////////////////////////////////////////////////
    // Responses and bus types
    //////////////////////////////////////////////////////////////

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    typedef enum logic [1:0] {
        GPIO  = 2'd0,
        CLINT = 2'd1,
        NONE  = 2'd2
    } io_target_t;

    // Single request on the data bus
    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] strb;
    } io_req_t;

    // Decoded command, address reduced to a window offset
    typedef struct packed {
        logic                wr;
        io_target_t          target;
        logic [OFFSET_W-1:0] offset;
        logic [XLEN-1:0]     wdata;
        logic [STRB_W-1:0]   strb;
    } io_cmd_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        resp_t           resp;
    } io_rsp_t;

endpackage

// File: logic/friscv_io_platform.sv
/* IO platform top level */

`timescale 1ns/1ps

module friscv_io_platform #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              rtc,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  friscv_io_pkg::io_req_t            req,
    output logic                              rsp_valid,
    input  logic                              rsp_ready,
    output friscv_io_pkg::io_rsp_t            rsp,
    input  logic [friscv_io_pkg::XLEN-1:0]    gpio_in,
    output logic [friscv_io_pkg::XLEN-1:0]    gpio_out,
    output logic                              sw_irq,
    output logic                              timer_irq
);

    // Decoder to queue
    logic                   cmd_valid;
    logic                   cmd_ready;
    friscv_io_pkg::io_cmd_t cmd;

    // Queue to register block
    logic                   q_valid;
    logic                   q_ready;
    friscv_io_pkg::io_cmd_t q_cmd;

    friscv_io_decoder decoder (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd)
    );

    friscv_io_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_valid (cmd_valid),
        .wr_ready (cmd_ready),
        .wr_cmd   (cmd),
        .rd_valid (q_valid),
        .rd_ready (q_ready),
        .rd_cmd   (q_cmd)
    );

    friscv_io_registers registers (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rtc       (rtc),
        .cmd_valid (q_valid),
        .cmd_ready (q_ready),
        .cmd       (q_cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

endmodule

// File: logic/friscv_io_queue.sv
/* IO command FIFO */

`timescale 1ns/1ps

module friscv_io_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic                    wr_valid,
    output logic                    wr_ready,
    input  friscv_io_pkg::io_cmd_t  wr_cmd,
    output logic                    rd_valid,
    input  logic                    rd_ready,
    output friscv_io_pkg::io_cmd_t  rd_cmd
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    friscv_io_pkg::io_cmd_t mem [QUEUE_DEPTH];

    // Extra MSB tells a full queue from an empty one
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           push;
    logic           pop;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_cmd;
        end
    end

    // Head entry shows up the cycle after it is written
    assign rd_cmd = mem[rd_ptr[PTR_W-1:0]];

endmodule

// File: logic/friscv_io_registers.sv
/* GPIO and CLINT registers */

`timescale 1ns/1ps

module friscv_io_registers (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              rtc,
    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  friscv_io_pkg::io_cmd_t            cmd,
    output logic                              rsp_valid,
    input  logic                              rsp_ready,
    output friscv_io_pkg::io_rsp_t            rsp,
    input  logic [friscv_io_pkg::XLEN-1:0]    gpio_in,
    output logic [friscv_io_pkg::XLEN-1:0]    gpio_out,
    output logic                              sw_irq,
    output logic                              timer_irq
);

    localparam int XLEN   = friscv_io_pkg::XLEN;
    localparam int STRB_W = friscv_io_pkg::STRB_W;

    logic                   take;
    logic                   wr_gpio;
    logic                   wr_clint;
    logic [2:0]             rtc_sync;
    logic                   rtc_rise;
    logic                   msip;
    logic [2*XLEN-1:0]      mtime;
    logic [2*XLEN-1:0]      mtime_next;
    logic [2*XLEN-1:0]      mtimecmp;
    logic [XLEN-1:0]        rdata;
    friscv_io_pkg::resp_t   resp;
    friscv_io_pkg::io_rsp_t rsp_next;

    function automatic logic [XLEN-1:0] merge_bytes(
        input logic [XLEN-1:0]   old_val,
        input logic [XLEN-1:0]   new_val,
        input logic [STRB_W-1:0] strb
    );
        logic [XLEN-1:0] res;
        res = old_val;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // One command per free response slot
    assign cmd_ready = !rsp_valid || rsp_ready;
    assign take      = cmd_valid && cmd_ready;
    assign wr_gpio   = take && cmd.wr && (cmd.target == friscv_io_pkg::GPIO);
    assign wr_clint  = take && cmd.wr && (cmd.target == friscv_io_pkg::CLINT);

    //////////////////////////////////////////////////////////////
    // RTC synchronizer and mtime
    //////////////////////////////////////////////////////////////

    // Bits 1:0 synchronize, bit 2 holds the previous level
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rtc_sync <= '0;
        end else begin
            rtc_sync <= {rtc_sync[1:0], rtc};
        end
    end

    assign rtc_rise = rtc_sync[1] && !rtc_sync[2];

    // Software write wins over the tick
    always_comb begin
        mtime_next = mtime;
        if (wr_clint && cmd.offset == friscv_io_pkg::REG_MTIME_LO) begin
            mtime_next[XLEN-1:0] = merge_bytes(mtime[XLEN-1:0], cmd.wdata, cmd.strb);
        end else if (wr_clint && cmd.offset == friscv_io_pkg::REG_MTIME_HI) begin
            mtime_next[2*XLEN-1:XLEN] = merge_bytes(mtime[2*XLEN-1:XLEN], cmd.wdata,
                                                    cmd.strb);
        end else if (rtc_rise) begin
            mtime_next = mtime + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out <= '0;
            msip     <= 1'b0;
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime_next;
            if (wr_gpio && cmd.offset == friscv_io_pkg::REG_GPIO_OUT) begin
                gpio_out <= merge_bytes(gpio_out, cmd.wdata, cmd.strb);
            end
            if (wr_clint && cmd.offset == friscv_io_pkg::REG_MSIP && cmd.strb[0]) begin
                msip <= cmd.wdata[0];
            end
            if (wr_clint && cmd.offset == friscv_io_pkg::REG_MTIMECMP_LO) begin
                mtimecmp[XLEN-1:0] <= merge_bytes(mtimecmp[XLEN-1:0], cmd.wdata, cmd.strb);
            end
            if (wr_clint && cmd.offset == friscv_io_pkg::REG_MTIMECMP_HI) begin
                mtimecmp[2*XLEN-1:XLEN] <= merge_bytes(mtimecmp[2*XLEN-1:XLEN],
                                                       cmd.wdata, cmd.strb);
            end
        end
    end

    assign sw_irq    = msip;
    assign timer_irq = mtime >= mtimecmp;

    //////////////////////////////////////////////////////////////
    // Read mux and response register
    //////////////////////////////////////////////////////////////

    always_comb begin
        rdata = '0;
        resp  = friscv_io_pkg::RESP_OKAY;
        case (cmd.target)
            friscv_io_pkg::GPIO: begin
                case (cmd.offset)
                    friscv_io_pkg::REG_GPIO_OUT: rdata = gpio_out;
                    friscv_io_pkg::REG_GPIO_IN:  rdata = gpio_in;
                    default:                     rdata = '0;
                endcase
            end
            friscv_io_pkg::CLINT: begin
                case (cmd.offset)
                    friscv_io_pkg::REG_MSIP:        rdata = {{(XLEN-1){1'b0}}, msip};
                    friscv_io_pkg::REG_MTIME_LO:    rdata = mtime[XLEN-1:0];
                    friscv_io_pkg::REG_MTIME_HI:    rdata = mtime[2*XLEN-1:XLEN];
                    friscv_io_pkg::REG_MTIMECMP_LO: rdata = mtimecmp[XLEN-1:0];
                    friscv_io_pkg::REG_MTIMECMP_HI: rdata = mtimecmp[2*XLEN-1:XLEN];
                    default:                        rdata = '0;
                endcase
            end
            default: resp = friscv_io_pkg::RESP_DECERR;
        endcase
        // Writes answer with zero data
        rsp_next.rdata = cmd.wr ? '0 : rdata;
        rsp_next.resp  = resp;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            rsp <= rsp_next;
        end
    end

endmodule

// File: verif/friscv_io_platform_tb.sv
/* IO platform testbench */

`timescale 1ns/1ps

module friscv_io_platform_tb;

    localparam int CLK_HALF  = 10;
    localparam int DRIVE_DLY = 2;

    logic                   aclk;
    logic                   arst_n;
    logic                   rtc;
    logic                   req_valid;
    logic                   req_ready;
    friscv_io_pkg::io_req_t req;
    logic                   rsp_valid;
    logic                   rsp_ready;
    friscv_io_pkg::io_rsp_t rsp;
    logic [31:0]            gpio_in;
    logic [31:0]            gpio_out;
    logic                   sw_irq;
    logic                   timer_irq;

    // Parsed data file, one entry per operation
    logic [7:0]  op_code [$];
    logic [31:0] field_a [$];
    logic [31:0] field_b [$];
    logic [31:0] field_c [$];
    logic [31:0] field_d [$];

    // Responses still owed by the DUT, oldest first
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [1:0]  exp_resp [$];
    logic        exp_read [$];

    logic [31:0] gpio_model;
    integer      seed;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    friscv_io_platform #(
        .QUEUE_DEPTH (4)
    ) dut (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rtc       (rtc),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        assert (cycle_count < cycle_limit) else
            stop_run($sformatf("Timeout: test did not finish within %0d cycles", cycle_limit));
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Stopping on first error");
    endtask

    // Bytes with a set strobe take the new value
    function automatic logic [31:0] apply_strobes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    ////////////////////////////////////////////////////////////
    // Data file
    ////////////////////////////////////////////////////////////

    task automatic load_testdata();
        integer          fd;
        integer          code;
        logic [7:0]      op;
        logic [8*128-1:0] rest;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     d;
        fd = $fopen("verif/friscv_io_testdata.txt", "r");
        assert (fd != 0) else
            stop_run("Cannot open test data file verif/friscv_io_testdata.txt");
        while (!$feof(fd)) begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            code = $fscanf(fd, " %c", op);
            if (code == 1) begin
                case (op)
                    "#": code = $fgets(rest, fd);
                    "W": code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    "R": code = $fscanf(fd, "%h %h %h", a, b, c);
                    "G", "T": code = $fscanf(fd, "%h", a);
                    "I": code = $fscanf(fd, "%h %h", a, b);
                    default: stop_run($sformatf("Unknown operation '%c' in test data", op));
                endcase
                if (op != "#") begin
                    op_code.push_back(op);
                    field_a.push_back(a);
                    field_b.push_back(b);
                    field_c.push_back(c);
                    field_d.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////////////////////////

    task automatic send_request(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb);
        logic accepted;
        req_valid = 1'b1;
        req.wr    = wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.strb  = strb;
        // req_ready only moves on a clock edge, so it is stable here
        accepted = 1'b0;
        while (!accepted) begin
            accepted = req_ready;
            @(posedge aclk);
            #DRIVE_DLY;
        end
        req_valid = 1'b0;
    endtask

    task automatic expect_response(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [1:0] resp, input logic is_read);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_resp.push_back(resp);
        exp_read.push_back(is_read);
    endtask

    task automatic check_response();
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        is_read;
        assert (exp_resp.size() != 0) else
            stop_run("DUT returned a response with no request outstanding");
        addr    = exp_addr.pop_front();
        data    = exp_data.pop_front();
        resp    = exp_resp.pop_front();
        is_read = exp_read.pop_front();
        assert (rsp.resp === resp) else
            stop_run($sformatf("MISMATCH at %0t: addr 0x%08h resp %0d, expected %0d",
                               $time, addr, rsp.resp, resp));
        if (is_read) begin
            assert (rsp.rdata === data) else
                stop_run($sformatf("MISMATCH at %0t: addr 0x%08h data 0x%08h, expected 0x%08h",
                                   $time, addr, rsp.rdata, data));
        end
    endtask

    // Wait for every outstanding response, then compare the GPIO pins
    task automatic drain_responses();
        while (exp_resp.size() != 0) begin
            @(posedge aclk);
            #DRIVE_DLY;
        end
        assert (gpio_out === gpio_model) else
            stop_run($sformatf("MISMATCH at %0t: gpio_out 0x%08h, expected 0x%08h",
                               $time, gpio_out, gpio_model));
    endtask

    task automatic toggle_rtc(input int count);
        repeat (count) begin
            rtc = 1'b1;
            repeat (3) @(posedge aclk);
            #DRIVE_DLY;
            rtc = 1'b0;
            repeat (3) @(posedge aclk);
            #DRIVE_DLY;
        end
        // Last edge still in the synchronizer
        repeat (3) @(posedge aclk);
        #DRIVE_DLY;
    endtask

    ////////////////////////////////////////////////////////////
    // Response side with random stalls
    ////////////////////////////////////////////////////////////

    initial begin : collect_responses
        int   stall;
        logic got_rsp;
        seed      = 32'ha3ac_cac8;
        rsp_ready = 1'b0;
        wait (arst_n === 1'b1);
        @(posedge aclk);
        #DRIVE_DLY;
        forever begin
            stall     = $random(seed) & 7;
            rsp_ready = 1'b0;
            repeat (stall) begin
                @(posedge aclk);
                #DRIVE_DLY;
            end
            rsp_ready = 1'b1;
            // Response is checked before the edge that takes it
            got_rsp = 1'b0;
            while (!got_rsp) begin
                got_rsp = rsp_valid;
                if (got_rsp) begin
                    check_response();
                end
                @(posedge aclk);
                #DRIVE_DLY;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////

    initial begin : run_tests
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        arst_n     = 1'b0;
        rtc        = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        gpio_in    = '0;
        gpio_model = '0;
        load_testdata();
        cycle_limit = 40 * op_code.size() + 100;
        repeat (3) @(posedge aclk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        assert (req_ready === 1'b1 && rsp_valid === 1'b0 && gpio_out === 32'h0) else
            stop_run("DUT outputs not in their reset state after reset");
        for (int i = 0; i < op_code.size(); i++) begin
            a = field_a[i];
            b = field_b[i];
            c = field_c[i];
            d = field_d[i];
            case (op_code[i])
                "W": begin
                    expect_response(a, 32'h0, d[1:0], 1'b0);
                    // gpio_out sits at the window base
                    if (a == friscv_io_pkg::IO_BASE && d[1:0] == friscv_io_pkg::RESP_OKAY) begin
                        gpio_model = apply_strobes(gpio_model, b, c[3:0]);
                    end
                    send_request(1'b1, a, b, c[3:0]);
                end
                "R": begin
                    expect_response(a, b, c[1:0], 1'b1);
                    send_request(1'b0, a, 32'h0, 4'h0);
                end
                "G": begin
                    drain_responses();
                    gpio_in = a;
                end
                "T": begin
                    drain_responses();
                    toggle_rtc(a);
                end
                default: begin
                    drain_responses();
                    assert (sw_irq === a[0] && timer_irq === b[0]) else
                        stop_run($sformatf("MISMATCH at %0t: sw_irq %b timer_irq %b, %s %b %b",
                                           $time, sw_irq, timer_irq, "expected",
                                           a[0], b[0]));
                end
            endcase
        end
        drain_responses();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verif/friscv_io_testdata.txt
# W addr data strb resp | R addr data resp | G gpio_in | T rtc_pulses | I sw_irq timer_irq
# All fields hexadecimal, IO window at 00100000
I 0 0
R 00100000 00000000 0
W 00100000 a1b2c3d4 f 0
W 00100000 55667788 5 0
R 00100000 a166c388 0
W 00100000 ffeeddcc 8 0
R 00100000 ff66c388 0
G 12345678
R 00100004 12345678 0
W 00100004 deadbeef f 0
R 00100004 12345678 0
R 00100014 00000000 3
W 00100008 11111111 f 3
R 000ffffc 00000000 3
R 00100040 00000000 3
R 00100000 ff66c388 0
R 0010002c 00000000 3
R 00100024 ffffffff 0
R 00100004 12345678 0
W 0010001c fffffffe f 0
W 00100020 00000007 f 0
T 3
R 0010001c 00000001 0
R 00100020 00000008 0
W 00100024 00000001 f 0
I 0 0
W 00100028 00000008 f 0
I 0 1
W 00100024 ffffffff f 0
W 00100028 ffffffff f 0
I 0 0
W 00100018 00000001 1 0
I 1 0
R 00100018 00000001 0
W 00100018 00000000 f 0
I 0 0

// File: verilog.f
logic/friscv_io_pkg.sv
logic/friscv_io_decoder.sv
logic/friscv_io_queue.sv
logic/friscv_io_registers.sv
logic/friscv_io_platform.sv
verif/friscv_io_platform_tb.sv
